//--- verilog/dct16_pkg.sv
// shared widths, coefficient table, row types and output truncation; imported by every dct16 block
`default_nettype none

package dct16_pkg;

    // transform size and datapath widths
    localparam int N_POINTS   = 16;
    localparam int SAMPLE_W   = 8;
    localparam int COEF_W     = 7;
    localparam int ACC_W      = 21;
    localparam int OUT_W      = 11;
    localparam int FRAC_SHIFT = 7;

    // scale used by X0 and X8, equal to C(0) and C(8)
    localparam int DC_COEF    = 32;

    // coefficient magnitudes C(0)..C(15)
    // C(m) is the cosine of m*pi/32 in 7-bit integer form
    localparam logic [COEF_W-1:0] COEF [0:15] = '{
        7'd32, 7'd45, 7'd44, 7'd43, 7'd42, 7'd40, 7'd38, 7'd35,
        7'd32, 7'd29, 7'd25, 7'd21, 7'd17, 7'd13, 7'd9,  7'd4
    };

    // one unsigned pixel
    typedef logic [SAMPLE_W-1:0] sample_t;

    // sample 0 sits in the top byte
    typedef sample_t [0:N_POINTS-1] row_in_t;

    // butterfly tree results, one bit wider per level
    // eee_sum can reach 4080, so it stays unsigned
    typedef struct packed {
        logic [0:7][SAMPLE_W:0]     odd_diff;
        logic [0:3][SAMPLE_W+1:0]   eo_diff;
        logic [0:1][SAMPLE_W+2:0]   eeo_diff;
        logic [SAMPLE_W+3:0]        eee_sum;
        logic signed [SAMPLE_W+3:0] eee_diff;
    } bfly_t;

    // full precision term before truncation
    typedef logic signed [ACC_W-1:0] acc_t;

    // eight terms of one parity, ascending k
    typedef acc_t [0:N_POINTS/2-1] half_acc_t;

    // one output frequency term
    typedef logic signed [OUT_W-1:0] out_t;

    // X0 in the top field
    typedef out_t [0:N_POINTS-1] row_out_t;

    // arithmetic shift by 7, then keep the low 11 bits
    // out of range values simply wrap
    function automatic out_t trunc_acc(acc_t acc);
        acc_t shifted;
        shifted = acc >>> FRAC_SHIFT;
        return shifted[OUT_W-1:0];
    endfunction

endpackage

`default_nettype wire

//--- verilog/dct16_butterfly.sv
// three-level add/subtract tree over mirrored samples, feeds the even and odd rotators
`default_nettype none

module dct16_butterfly (
    input  dct16_pkg::row_in_t rows,
    output dct16_pkg::bfly_t   bfly
);
    import dct16_pkg::*;

    // level sums, all non-negative
    logic [SAMPLE_W:0]   e_sum [0:7];
    logic [SAMPLE_W+1:0] s_sum [0:3];
    logic [SAMPLE_W+2:0] v_sum [0:1];

    always_comb begin
        // level 1: x(n) against x(15-n)
        // zero-extend so the difference is a 9-bit two's complement value
        for (int n = 0; n < N_POINTS / 2; n++) begin
            e_sum[n] = {1'b0, rows[n]} + {1'b0, rows[N_POINTS-1-n]};
            bfly.odd_diff[n] = {1'b0, rows[n]} - {1'b0, rows[N_POINTS-1-n]};
        end

        // level 2: e(n) against e(7-n)
        for (int n = 0; n < N_POINTS / 4; n++) begin
            s_sum[n] = {1'b0, e_sum[n]} + {1'b0, e_sum[N_POINTS/2-1-n]};
            bfly.eo_diff[n] = {1'b0, e_sum[n]} - {1'b0, e_sum[N_POINTS/2-1-n]};
        end

        // level 3: s(n) against s(3-n)
        for (int n = 0; n < N_POINTS / 8; n++) begin
            v_sum[n] = {1'b0, s_sum[n]} + {1'b0, s_sum[N_POINTS/4-1-n]};
            bfly.eeo_diff[n] = {1'b0, s_sum[n]} - {1'b0, s_sum[N_POINTS/4-1-n]};
        end

        // final pair for X0 and X8
        bfly.eee_sum  = {1'b0, v_sum[0]} + {1'b0, v_sum[1]};
        // range is +-2040, fits the signed 12-bit field
        bfly.eee_diff = {1'b0, v_sum[0]} - {1'b0, v_sum[1]};
    end

endmodule

`default_nettype wire

//--- verilog/dct16_even_rotator.sv
// constant-coefficient products for X0..X14 even terms, driven from the butterfly results
`default_nettype none

module dct16_even_rotator (
    input  dct16_pkg::bfly_t     bfly,
    output dct16_pkg::half_acc_t even_acc
);
    import dct16_pkg::*;

    // positive signed magnitudes
    // each sum below applies the sign for its p
    localparam logic signed [COEF_W:0] C_DC = (COEF_W + 1)'(DC_COEF);
    localparam logic signed [COEF_W:0] C_2  = $signed({1'b0, COEF[2]});
    localparam logic signed [COEF_W:0] C_4  = $signed({1'b0, COEF[4]});
    localparam logic signed [COEF_W:0] C_6  = $signed({1'b0, COEF[6]});
    localparam logic signed [COEF_W:0] C_10 = $signed({1'b0, COEF[10]});
    localparam logic signed [COEF_W:0] C_12 = $signed({1'b0, COEF[12]});
    localparam logic signed [COEF_W:0] C_14 = $signed({1'b0, COEF[14]});

    // signed views of the butterfly fields
    logic signed [SAMPLE_W+4:0] eee_sum_s;
    logic signed [SAMPLE_W+2:0] eeo [0:1];
    logic signed [SAMPLE_W+1:0] eo  [0:3];

    always_comb begin
        // unsigned sum, one extra zero bit keeps it positive
        eee_sum_s = $signed({1'b0, bfly.eee_sum});
        for (int n = 0; n < 2; n++) begin
            eeo[n] = $signed(bfly.eeo_diff[n]);
        end
        for (int n = 0; n < 4; n++) begin
            eo[n] = $signed(bfly.eo_diff[n]);
        end
    end

    // index j holds X(2j)
    // p = (2n+1)*k mod 64 picks each coefficient
    always_comb begin
        // X0 sums all sixteen samples at +32
        even_acc[0] = C_DC * eee_sum_s;
        // X8: p = 8, 24 gives +32, -32 on v0, v1
        even_acc[4] = C_DC * bfly.eee_diff;

        // X4: p = 4, 12
        even_acc[2] = C_4 * eeo[0] + C_12 * eeo[1];
        // X12: p = 12, 36
        even_acc[6] = C_12 * eeo[0] - C_4 * eeo[1];

        // X2: p = 2, 6, 10, 14, all in the first quarter
        even_acc[1] = C_2 * eo[0] + C_6 * eo[1] + C_10 * eo[2] + C_14 * eo[3];
        // X6: p = 6, 18, 30, 42
        even_acc[3] = C_6 * eo[0] - C_14 * eo[1] - C_2 * eo[2] - C_10 * eo[3];
        // X10: p = 10, 30, 50, 6
        even_acc[5] = C_10 * eo[0] - C_2 * eo[1] + C_14 * eo[2] + C_6 * eo[3];
        // X14: p = 14, 42, 6, 34
        even_acc[7] = C_14 * eo[0] - C_10 * eo[1] + C_6 * eo[2] - C_2 * eo[3];
    end

endmodule

`default_nettype wire

//--- verilog/dct16_odd_rotator.sv
// 8x8 constant-coefficient product of the first-level differences that gives the odd terms X1..X15
`default_nettype none

module dct16_odd_rotator (
    input  dct16_pkg::bfly_t     bfly,
    output dct16_pkg::half_acc_t odd_acc
);
    import dct16_pkg::*;

    // signed matrix coefficient for term k and sample n
    // only odd k reach this block, so p is always odd and never a zero crossing
    function automatic logic signed [COEF_W:0] rule_coef(int k, int n);
        int p;
        p = ((2 * n + 1) * k) % 64;
        // positive in the first quarter
        if (p < 16) begin
            return $signed({1'b0, COEF[p]});
        end
        // mirrored and negative in the second quarter
        if (p <= 32) begin
            return -$signed({1'b0, COEF[32-p]});
        end
        // negative in the third quarter
        if (p < 48) begin
            return -$signed({1'b0, COEF[p-32]});
        end
        // last quarter is mirrored and positive again
        return $signed({1'b0, COEF[64-p]});
    endfunction

    // signed view of the differences
    logic signed [SAMPLE_W:0] od [0:7];

    always_comb begin
        for (int n = 0; n < N_POINTS / 2; n++) begin
            od[n] = $signed(bfly.odd_diff[n]);
        end
    end

    // index j holds X(2j+1)
    // x(15-n) carries the opposite sign, which the difference already holds
    always_comb begin
        acc_t sum;
        for (int j = 0; j < N_POINTS / 2; j++) begin
            sum = '0;
            // loops unroll and every coefficient folds to a constant
            for (int n = 0; n < N_POINTS / 2; n++) begin
                sum = sum + od[n] * rule_coef(2 * j + 1, n);
            end
            odd_acc[j] = sum;
        end
    end

endmodule

`default_nettype wire

//--- verilog/dct16_row.sv
// top of the 16-point dct row transform: input register, butterfly, rotators, output register
`default_nettype none

module dct16_row (
    input  logic                clk,
    input  logic                arst_n,
    input  dct16_pkg::row_in_t  samples,
    output dct16_pkg::row_out_t coeffs
);
    import dct16_pkg::*;

    // row held for one cycle ahead of the transform
    row_in_t   samples_q;
    bfly_t     bfly;
    half_acc_t even_acc;
    half_acc_t odd_acc;
    // truncated terms in frequency order
    row_out_t  coeffs_d;

    // input register, edge N
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            samples_q <= '0;
        end else begin
            samples_q <= samples;
        end
    end

    // combinational transform, zero latency
    dct16_butterfly u_butterfly (
        .rows (samples_q),
        .bfly (bfly)
    );

    dct16_even_rotator u_even (
        .bfly     (bfly),
        .even_acc (even_acc)
    );

    dct16_odd_rotator u_odd (
        .bfly    (bfly),
        .odd_acc (odd_acc)
    );

    // interleave halves back to X0..X15
    // and drop the seven fraction bits
    always_comb begin
        for (int j = 0; j < N_POINTS / 2; j++) begin
            coeffs_d[2*j]   = trunc_acc(even_acc[j]);
            coeffs_d[2*j+1] = trunc_acc(odd_acc[j]);
        end
    end

    // output register, edge N+1
    // a new row lands here every cycle
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            coeffs <= '0;
        end else begin
            coeffs <= coeffs_d;
        end
    end

endmodule

`default_nettype wire

//--- test/dct16_row_tb.sv
// testbench for dct16_row: drives rows on samples, models the integer dct matrix, checks coeffs
`default_nettype none

module dct16_row_tb;
    import dct16_pkg::*;

    localparam int N_TESTS     = 6;
    localparam int DRAIN_LIMIT = 50;
    // integer cosine magnitudes C(0)..C(15)
    localparam int COS_TAB [16] = '{32, 45, 44, 43, 42, 40, 38, 35,
                                    32, 29, 25, 21, 17, 13, 9, 4};
    localparam int LEVELS [8] = '{0, 1, 3, 64, 127, 128, 200, 255};

    logic     clk = 1'b0;
    logic     arst_n;
    row_in_t  samples;
    row_out_t coeffs;

    // test id of the row on samples, travels with it into the queue
    int       row_tag;
    int       cur_id;
    integer   seed;
    bit       timed_out;
    string    test_name [N_TESTS];
    int       check_cnt [N_TESTS];
    int       error_cnt [N_TESTS];
    // compares against the model only
    int       ref_cnt   [N_TESTS];

    // rows seen at the last three falling edges
    row_in_t  row_q [$];
    int       tag_q [$];

    dct16_row u_dut (
        .clk     (clk),
        .arst_n  (arst_n),
        .samples (samples),
        .coeffs  (coeffs)
    );

    initial begin
        forever begin
            #50 clk = ~clk;
        end
    end

    // signed matrix entry for term k and sample n
    function automatic int matrix_coef(input int k, input int n);
        int p;
        p = ((2 * n + 1) * k) % 64;
        if (k == 0) return 32;
        if (p < 16) return COS_TAB[p];
        if (p == 16) return 0;
        if (p <= 32) return -COS_TAB[32 - p];
        if (p < 48) return -COS_TAB[p - 32];
        if (p == 48) return 0;
        return COS_TAB[64 - p];
    endfunction

    // direct 16x16 product, then floor by 128 and wrap to 11 bits
    function automatic row_out_t dct_ref(input row_in_t row);
        row_out_t res;
        int       acc;
        int       scaled;
        for (int k = 0; k < N_POINTS; k++) begin
            acc = 0;
            for (int n = 0; n < N_POINTS; n++) begin
                acc += int'(row[n]) * matrix_coef(k, n);
            end
            scaled = acc >>> 7;
            res[k] = scaled[10:0];
        end
        return res;
    endfunction

    function automatic row_in_t fill_row(input int v);
        row_in_t row;
        for (int n = 0; n < N_POINTS; n++) begin
            row[n] = v[7:0];
        end
        return row;
    endfunction

    // large swing patterns, idx 7 and up give the complements
    function automatic row_in_t pattern_row(input int idx);
        row_in_t row;
        int      v;
        for (int n = 0; n < N_POINTS; n++) begin
            case (idx % 7)
                0: v = (n % 2 == 0) ? 255 : 0;
                1: v = (n % 2 == 1) ? 255 : 0;
                2: v = ((n / 2) % 2 == 0) ? 255 : 0;
                3: v = (n < 8) ? 255 : 0;
                4: v = n * 17;
                5: v = 255 - n * 17;
                default: v = (n % 4 == 0) ? 255 : 0;
            endcase
            if (idx >= 7) begin
                v = 255 - v;
            end
            row[n] = v[7:0];
        end
        return row;
    endfunction

    task automatic rand_row(output row_in_t row);
        int r;
        for (int n = 0; n < N_POINTS; n++) begin
            r = $random(seed);
            row[n] = r[7:0];
        end
    endtask

    task automatic apply_row(input row_in_t row, input int id);
        @(posedge clk);
        samples <= row;
        row_tag <= id;
    endtask

    task automatic compare_row(input int id, input row_out_t exp_row);
        check_cnt[id]++;
        if (coeffs !== exp_row) begin
            error_cnt[id]++;
            $display("FAIL %s: expected %h, actual %h", test_name[id], exp_row, coeffs);
        end
    endtask

    // blocks until the test has target model compares, or gives up
    task automatic wait_checks(input int id, input int target);
        int cycles;
        cycles = 0;
        while (ref_cnt[id] < target && cycles < DRAIN_LIMIT) begin
            @(posedge clk);
            cycles++;
        end
        if (ref_cnt[id] < target) begin
            timed_out = 1'b1;
            $display("timeout in %s: only %0d of %0d results were compared after %0d cycles",
                     test_name[id], ref_cnt[id], target, DRAIN_LIMIT);
        end
    endtask

    task automatic report_test(input int id);
        $display("done %s: %0d checks, %0d errors", test_name[id], check_cnt[id], error_cnt[id]);
    endtask

    // outputs are stable at the falling edge
    // result of the row seen two falling edges ago is on coeffs now
    always @(negedge clk) begin
        if (!arst_n) begin
            row_q.delete();
            tag_q.delete();
            // asynchronous clear, no edge needed
            compare_row(cur_id, '0);
        end else begin
            row_q.push_back(samples);
            tag_q.push_back(row_tag);
            if (row_q.size() > 3) begin
                void'(row_q.pop_front());
                void'(tag_q.pop_front());
            end
            if (row_q.size() == 3) begin
                compare_row(tag_q[0], dct_ref(row_q[0]));
                ref_cnt[tag_q[0]]++;
            end else begin
                // cleared rows still in the pipeline
                compare_row(cur_id, '0);
            end
        end
    end

    initial begin
        row_in_t row;
        int      count;
        int      base;
        int      total_chk;
        int      total_err;
        test_name = '{"reset", "constant row", "single impulse", "alternating extremes",
                      "random stream", "mid-stream reset"};
        seed      = 89394;
        timed_out = 1'b0;
        arst_n    = 1'b0;
        samples   = '0;
        row_tag   = 0;
        cur_id    = 0;

        // zero rows keep flowing through reset release
        repeat (2) @(posedge clk);
        arst_n <= 1'b1;
        for (int i = 0; i < 4; i++) begin
            apply_row('0, 0);
        end
        wait_checks(0, 4);
        report_test(0);

        // X0 = 4v, all other terms zero
        cur_id = 1;
        for (int i = 0; i < 8; i++) begin
            apply_row(fill_row(LEVELS[i]), 1);
        end
        wait_checks(1, 8);
        report_test(1);

        // every matrix column, at full and at unit amplitude
        cur_id = 2;
        count  = 0;
        foreach (LEVELS[a]) begin
            if (LEVELS[a] == 255 || LEVELS[a] == 1) begin
                for (int pos = 0; pos < N_POINTS; pos++) begin
                    row      = '0;
                    row[pos] = LEVELS[a][7:0];
                    apply_row(row, 2);
                    count++;
                end
            end
        end
        wait_checks(2, count);
        report_test(2);

        cur_id = 3;
        for (int i = 0; i < 14; i++) begin
            apply_row(pattern_row(i), 3);
        end
        wait_checks(3, 14);
        report_test(3);

        // one row per cycle, two in flight
        cur_id = 4;
        for (int i = 0; i < 200; i++) begin
            rand_row(row);
            apply_row(row, 4);
        end
        wait_checks(4, 200);
        report_test(4);

        // reset lands on edges 12 and 13 while rows keep coming
        cur_id = 5;
        base   = 0;
        for (int i = 0; i < 30; i++) begin
            rand_row(row);
            apply_row(row, 5);
            if (i == 12) begin
                arst_n <= 1'b0;
            end
            if (i == 14) begin
                arst_n <= 1'b1;
                base = ref_cnt[5];
            end
        end
        wait_checks(5, base + 16);
        report_test(5);

        total_chk = 0;
        total_err = 0;
        for (int i = 0; i < N_TESTS; i++) begin
            total_chk += check_cnt[i];
            total_err += error_cnt[i];
        end
        $display("checks %0d, errors %0d, timeouts %0d", total_chk, total_err, timed_out);
        if (total_err == 0 && !timed_out) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- dct16_row.f
verilog/dct16_pkg.sv
verilog/dct16_butterfly.sv
verilog/dct16_even_rotator.sv
verilog/dct16_odd_rotator.sv
verilog/dct16_row.sv
test/dct16_row_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
# builds the dct16_row testbench with Verilator, runs it, and checks the log

cd "$(dirname "$0")" || exit 1

LOG=sim.log
BIN=dct16_row_sim

if ! verilator --binary --timing -Wno-fatal --top-module dct16_row_tb \
        -f dct16_row.f --Mdir obj_dir -o "$BIN"; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/"$BIN" > "$LOG" 2>&1
status=$?
cat "$LOG"

if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -qx "test passed" "$LOG"; then
    exit 0
fi
echo "pass message not found in $LOG"
exit 1
